// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

  localparam int addr_width = 32;
  localparam int fetch_bytes = 8;             // Two instructions per access.
  localparam int word_bits = fetch_bytes * 8;
  localparam int fetch_offset_bits = $clog2(fetch_bytes);
  localparam int mem_depth_log = 8;
  localparam int mem_depth = 1 << mem_depth_log;
  localparam int btc_index_bits = 4;
  localparam int btc_entries = 1 << btc_index_bits;
  localparam int btc_tag_bits = addr_width - btc_index_bits - fetch_offset_bits;
  localparam logic [addr_width-1:0] reset_pc = '0;

  typedef enum logic [1:0] {
    idle,
    busy,
    jump,
    inv
  } fetch_state_t;

  // Source of the next fetch address, highest priority first after sel_seq.
  typedef enum logic [2:0] {
    sel_seq,
    sel_trap,
    sel_mret,
    sel_pred,
    sel_miss,
    sel_jump,
    sel_fence
  } redirect_t;

  typedef struct packed {
    logic                  trap;
    logic                  mret;
    logic [addr_width-1:0] mtvec;
    logic [addr_width-1:0] mepc;
  } csr_ctrl_t;

  typedef struct packed {
    logic                  jump;
    logic [addr_width-1:0] jump_addr;
    logic                  fence;
    logic [addr_width-1:0] fence_npc;
    logic                  clear;
  } exec_ctrl_t;

  typedef struct packed {
    logic                  valid;
    logic [addr_width-1:0] pc;
    logic [addr_width-1:0] npc;
    logic [addr_width-1:0] target;
    logic                  taken;
  } resolve_t;

  typedef struct packed {
    logic [addr_width-1:0] get_pc;
    logic                  stall;
    logic                  clear;
    resolve_t              resolve;
  } btc_req_t;

  typedef struct packed {
    logic                  pred_branch;
    logic [addr_width-1:0] pred_baddr;  // Predicted target.
    logic [addr_width-1:0] pred_taddr;  // Pc of the predicted branch.
    logic                  pred_miss;
    logic [addr_width-1:0] pred_maddr;
  } btc_rsp_t;

  typedef struct packed {
    logic [btc_tag_bits-1:0] tag;
    logic [addr_width-1:0]   bpc;
    logic [addr_width-1:0]   target;
  } btc_entry_t;

  typedef struct packed {
    logic                  valid;
    logic                  fence;
    logic                  spec;
    logic [addr_width-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic                 ready;
    logic [word_bits-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic                  valid;
    logic [addr_width-1:0] addr;   // Byte address.
    logic [word_bits-1:0]  data;
  } mem_load_t;

  typedef struct packed {
    logic [addr_width-1:0] pc;
    logic [word_bits-1:0]  rdata;
    logic                  ready;
    logic                  taken;
    logic [addr_width-1:0] tpc;
  } fetch_out_t;

  typedef struct packed {
    fetch_state_t          state;
    logic [addr_width-1:0] pc;     // Address of the request in flight.
    logic                  valid;
    logic                  fence;
    logic                  spec;
    logic                  taken;
    logic [addr_width-1:0] tpc;
  } fetch_reg_t;

  localparam fetch_reg_t fetch_reg_init = '{
    state: idle,
    pc: reset_pc,
    valid: 1'b0,
    fence: 1'b0,
    spec: 1'b0,
    taken: 1'b0,
    tpc: '0
  };

endpackage

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
  input  logic                   clock,
  input  logic                   reset,
  input  fetch_pkg::csr_ctrl_t   csr,
  input  fetch_pkg::exec_ctrl_t  exec,
  input  fetch_pkg::resolve_t    resolve,
  input  fetch_pkg::btc_rsp_t    btc_rsp,
  output fetch_pkg::btc_req_t    btc_req,
  input  fetch_pkg::mem_rsp_t    mem_rsp,
  output fetch_pkg::mem_req_t    mem_req,
  output fetch_pkg::fetch_out_t  y,
  output fetch_pkg::fetch_out_t  q
);

  fetch_pkg::fetch_reg_t r;
  fetch_pkg::fetch_reg_t v;
  fetch_pkg::fetch_out_t q_r;
  fetch_pkg::redirect_t sel;
  logic [fetch_pkg::addr_width-1:0] target;
  logic advance;
  logic squash;
  logic beat;

  // A response is consumed only in busy.
  assign advance = (r.state == fetch_pkg::busy) && mem_rsp.ready;

  always_comb begin
    btc_req.get_pc = r.pc;
    btc_req.stall = !advance;
    btc_req.clear = exec.clear;
    btc_req.resolve = resolve;
  end

  always_comb begin
    if (csr.trap) begin
      sel = fetch_pkg::sel_trap;
    end else if (csr.mret) begin
      sel = fetch_pkg::sel_mret;
    end else if (btc_rsp.pred_branch) begin
      sel = fetch_pkg::sel_pred;
    end else if (btc_rsp.pred_miss) begin
      sel = fetch_pkg::sel_miss;
    end else if (exec.jump) begin
      sel = fetch_pkg::sel_jump;
    end else if (exec.fence) begin
      sel = fetch_pkg::sel_fence;
    end else begin
      sel = fetch_pkg::sel_seq;
    end
  end

  always_comb begin
    case (sel)
      fetch_pkg::sel_trap:  target = csr.mtvec;
      fetch_pkg::sel_mret:  target = csr.mepc;
      fetch_pkg::sel_pred:  target = btc_rsp.pred_baddr;
      fetch_pkg::sel_miss:  target = btc_rsp.pred_maddr;
      fetch_pkg::sel_jump:  target = exec.jump_addr;
      fetch_pkg::sel_fence: target = exec.fence_npc;
      default: target = r.pc + fetch_pkg::addr_width'(fetch_pkg::fetch_bytes);
    endcase
  end

  // Everything except a prediction kills the fetch in flight.
  assign squash = (sel != fetch_pkg::sel_seq) && (sel != fetch_pkg::sel_pred);

  always_comb begin
    v = r;
    v.valid = 1'b0;
    v.fence = 1'b0;
    v.spec = 1'b0;
    beat = 1'b0;
    case (r.state)
      fetch_pkg::idle: begin
        if (squash) begin
          v.pc = target;
        end
        if (!exec.clear) begin
          v.state = fetch_pkg::busy;
          v.valid = 1'b1;
          v.spec = squash;
          v.fence = (sel == fetch_pkg::sel_fence);
        end
      end
      fetch_pkg::busy: begin
        if (mem_rsp.ready) begin
          beat = !squash;
          v.pc = target;
          v.valid = 1'b1;
          v.spec = (sel != fetch_pkg::sel_seq);
          v.fence = (sel == fetch_pkg::sel_fence);  // Issued next cycle, memory idle.
          v.taken = (sel == fetch_pkg::sel_pred);
          v.tpc = (sel == fetch_pkg::sel_pred) ? btc_rsp.pred_taddr : '0;
        end else if (squash) begin
          v.pc = target;
          v.state = (sel == fetch_pkg::sel_fence) ? fetch_pkg::inv : fetch_pkg::jump;
        end
      end
      fetch_pkg::jump, fetch_pkg::inv: begin
        // Newer redirects overwrite the pending address.
        if (squash) begin
          v.pc = target;
          if (sel == fetch_pkg::sel_fence) begin
            v.state = fetch_pkg::inv;
          end
        end
        if (mem_rsp.ready) begin
          v.fence = (v.state == fetch_pkg::inv);
          v.state = fetch_pkg::busy;
          v.valid = 1'b1;
          v.spec = 1'b1;
          v.taken = 1'b0;
          v.tpc = '0;
        end
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    mem_req.valid = r.valid;
    mem_req.fence = r.fence;
    mem_req.spec = r.spec;
    mem_req.addr = r.pc;
    y.pc = r.pc;
    y.rdata = mem_rsp.rdata;
    y.ready = beat;
    y.taken = r.taken;
    y.tpc = r.tpc;
  end

  assign q = q_r;

  always_ff @(posedge clock) begin
    if (!reset) begin
      r <= fetch_pkg::fetch_reg_init;
      q_r <= '0;
    end else begin
      r <= v;
      q_r <= y;
    end
  end

endmodule

// ==== hdl/branch_target_cache.sv ====
`timescale 1ns/1ps

module branch_target_cache (
  input  logic                 clock,
  input  logic                 reset,
  input  fetch_pkg::btc_req_t  req,
  output fetch_pkg::btc_rsp_t  rsp
);

  logic [fetch_pkg::btc_entries-1:0] valid_q;
  fetch_pkg::btc_entry_t entries_q [fetch_pkg::btc_entries];

  logic [fetch_pkg::btc_index_bits-1:0] get_idx;
  logic [fetch_pkg::btc_index_bits-1:0] upd_idx;
  logic [fetch_pkg::btc_tag_bits-1:0] get_tag;
  logic [fetch_pkg::btc_tag_bits-1:0] upd_tag;
  fetch_pkg::btc_entry_t get_entry;
  fetch_pkg::btc_entry_t upd_entry;
  fetch_pkg::btc_entry_t new_entry;
  logic get_hit;
  logic upd_hit;
  logic held_same;

  always_comb begin
    get_idx = req.get_pc[fetch_pkg::fetch_offset_bits +: fetch_pkg::btc_index_bits];
    get_tag = req.get_pc[fetch_pkg::addr_width-1 -: fetch_pkg::btc_tag_bits];
    upd_idx = req.resolve.pc[fetch_pkg::fetch_offset_bits +: fetch_pkg::btc_index_bits];
    upd_tag = req.resolve.pc[fetch_pkg::addr_width-1 -: fetch_pkg::btc_tag_bits];
    get_entry = entries_q[get_idx];
    upd_entry = entries_q[upd_idx];
    get_hit = valid_q[get_idx] && (get_entry.tag == get_tag);
    upd_hit = valid_q[upd_idx] && (upd_entry.tag == upd_tag);
    held_same = upd_hit && (upd_entry.target == req.resolve.target);
    new_entry.tag = upd_tag;
    new_entry.bpc = req.resolve.pc;
    new_entry.target = req.resolve.target;
  end

  // Lookup on the fetch pc.
  always_comb begin
    rsp.pred_branch = get_hit && !req.stall && !req.clear;
    rsp.pred_baddr = get_entry.target;
    rsp.pred_taddr = get_entry.bpc;
  end

  // Resolved outcome against what the table held.
  always_comb begin
    if (req.resolve.taken) begin
      rsp.pred_miss = req.resolve.valid && !held_same;
      rsp.pred_maddr = req.resolve.target;
    end else begin
      rsp.pred_miss = req.resolve.valid && upd_hit;
      rsp.pred_maddr = req.resolve.npc;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid_q <= '0;
    end else if (req.clear) begin
      valid_q <= '0;
    end else if (req.resolve.valid) begin
      if (req.resolve.taken) begin
        valid_q[upd_idx] <= 1'b1;
      end else if (upd_hit) begin
        valid_q[upd_idx] <= 1'b0;  // Only drop our own entry.
      end
    end
  end

  always_ff @(posedge clock) begin
    if (req.resolve.valid && req.resolve.taken) begin
      entries_q[upd_idx] <= new_entry;
    end
  end

endmodule

// ==== hdl/instr_memory.sv ====
`timescale 1ns/1ps

module instr_memory (
  input  logic                  clock,
  input  logic                  reset,
  input  fetch_pkg::mem_load_t  load,
  input  fetch_pkg::mem_req_t   req,
  output fetch_pkg::mem_rsp_t   rsp
);

  logic [fetch_pkg::word_bits-1:0] mem [fetch_pkg::mem_depth];

  logic [fetch_pkg::mem_depth_log-1:0] req_idx;
  logic [fetch_pkg::mem_depth_log-1:0] raddr;
  logic [fetch_pkg::mem_depth_log-1:0] wbuf_idx;
  logic [fetch_pkg::word_bits-1:0] wbuf_data;
  logic [fetch_pkg::word_bits-1:0] rdata_q;
  logic wbuf_valid;
  logic fence_pend;
  logic ready_q;
  logic commit;

  assign req_idx = req.addr[fetch_pkg::fetch_offset_bits +: fetch_pkg::mem_depth_log];

  // Drain on a free cycle, on a fence, or when a new load pushes it out.
  assign commit = wbuf_valid && (!req.valid || req.fence || load.valid);

  always_ff @(posedge clock) begin
    if (!reset) begin
      wbuf_valid <= 1'b0;
      fence_pend <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      wbuf_valid <= load.valid || (wbuf_valid && !commit);
      fence_pend <= req.valid && req.fence;
      ready_q <= (req.valid && !req.fence) || fence_pend;
    end
  end

  always_ff @(posedge clock) begin
    if (load.valid) begin
      wbuf_idx <= load.addr[fetch_pkg::fetch_offset_bits +: fetch_pkg::mem_depth_log];
      wbuf_data <= load.data;
    end
    if (commit) begin
      mem[wbuf_idx] <= wbuf_data;
    end
    if (req.valid) begin
      raddr <= req_idx;
    end
    if (req.valid && !req.fence) begin
      rdata_q <= mem[req_idx];
    end else if (fence_pend) begin
      rdata_q <= mem[raddr];     // Write already committed.
    end
  end

  always_comb begin
    rsp.ready = ready_q;
    rsp.rdata = rdata_q;
  end

endmodule

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
  input  logic                   clock,
  input  logic                   reset,
  input  fetch_pkg::csr_ctrl_t   csr,
  input  fetch_pkg::exec_ctrl_t  exec,
  input  fetch_pkg::resolve_t    resolve,
  input  fetch_pkg::mem_load_t   load,
  output fetch_pkg::fetch_out_t  fetch,
  output fetch_pkg::fetch_out_t  fetch_q
);

  fetch_pkg::btc_req_t btc_req;
  fetch_pkg::btc_rsp_t btc_rsp;
  fetch_pkg::mem_req_t mem_req;
  fetch_pkg::mem_rsp_t mem_rsp;

  fetch_stage u_fetch (
    .clock   (clock),
    .reset   (reset),
    .csr     (csr),
    .exec    (exec),
    .resolve (resolve),
    .btc_rsp (btc_rsp),
    .btc_req (btc_req),
    .mem_rsp (mem_rsp),
    .mem_req (mem_req),
    .y       (fetch),
    .q       (fetch_q)
  );

  branch_target_cache u_btc (
    .clock (clock),
    .reset (reset),
    .req   (btc_req),
    .rsp   (btc_rsp)
  );

  instr_memory u_mem (
    .clock (clock),
    .reset (reset),
    .load  (load),
    .req   (mem_req),
    .rsp   (mem_rsp)
  );

endmodule

// ==== testbench/fetch_unit_assertions.sv ====
`timescale 1ns/1ps

module fetch_unit_assertions (
  input logic                   clock,
  input logic                   reset,
  input fetch_pkg::mem_req_t    mem_req,
  input fetch_pkg::mem_rsp_t    mem_rsp,
  input fetch_pkg::fetch_reg_t  r,
  input fetch_pkg::exec_ctrl_t  exec
);

  // A fenced request never lands on a response cycle.
  assert property (@(posedge clock) disable iff (!reset)
      !(mem_req.valid && mem_req.fence && mem_rsp.ready))
    else $error("Fenced fetch request issued in the same cycle as a memory response");

  // One response per request, never back to back.
  assert property (@(posedge clock) disable iff (!reset)
      mem_rsp.ready |=> !mem_rsp.ready)
    else $error("Memory ready was high for two consecutive cycles");

  assert property (@(posedge clock) disable iff (!reset)
      (r.state == fetch_pkg::idle && exec.clear) |=> !mem_req.valid)
    else $error("Fetch request issued while idle with clear held high");

endmodule

// ==== testbench/fetch_unit_tb.sv ====
`timescale 1ns/1ps

module fetch_unit_tb;

  typedef struct packed {
    int          after;      // Beats delivered before the row is applied.
    logic [5:0]  kind;
    logic [31:0] mtvec;
    logic [31:0] mepc;
    logic [31:0] jaddr;
    logic [31:0] faddr;
    logic [31:0] bpc;
    logic [31:0] btgt;
    logic [31:0] exp_pc;     // Pc of the next delivered beat.
  } row_t;

  localparam logic [5:0] k_trap = 6'b000001;
  localparam logic [5:0] k_mret = 6'b000010;
  localparam logic [5:0] k_jump = 6'b000100;
  localparam logic [5:0] k_fence = 6'b001000;
  localparam logic [5:0] k_taken = 6'b010000;
  localparam logic [5:0] k_not_taken = 6'b100000;
  localparam int row_count = 10;
  localparam int total_beats = 32;
  localparam int cycle_limit = 40 * total_beats;

  logic clock;
  logic reset;
  fetch_pkg::csr_ctrl_t csr;
  fetch_pkg::exec_ctrl_t exec;
  fetch_pkg::resolve_t resolve;
  fetch_pkg::mem_load_t load;
  fetch_pkg::fetch_out_t fetch;
  fetch_pkg::fetch_out_t fetch_q;

  row_t rows [row_count];
  logic [63:0] copy [256];
  logic [31:0] lfsr_state;
  logic btc_valid [16];
  logic [31:0] btc_pc [16];
  logic [31:0] btc_target [16];

  logic running = 1'b0;
  int beat_count = 0;
  int pc_errors = 0;
  int data_errors = 0;
  int flag_errors = 0;
  int cycles = 0;
  int redirect_seq = 0;
  int redirect_seen = 0;
  logic [31:0] redirect_pc = '0;
  logic [31:0] next_pc = '0;
  logic [31:0] next_tpc = '0;
  logic next_taken = 1'b0;
  logic [31:0] cur_pc;
  logic [31:0] cur_tpc;
  logic cur_taken;
  logic [31:0] last_pc = '0;
  logic [31:0] last_tpc = '0;
  logic last_taken = 1'b0;
  logic last_beat = 1'b0;
  logic [3:0] bidx;

  fetch_unit i_dut (
    .clock   (clock),
    .reset   (reset),
    .csr     (csr),
    .exec    (exec),
    .resolve (resolve),
    .load    (load),
    .fetch   (fetch),
    .fetch_q (fetch_q)
  );

  bind fetch_stage fetch_unit_assertions u_assertions (
    .clock   (clock),
    .reset   (reset),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .r       (r),
    .exec    (exec)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function logic [63:0] random_word();
    logic [63:0] w;
    w = '0;
    for (int i = 0; i < 64; i++) begin
      w = {w[62:0], lfsr_state[0]};  // One step per bit.
      lfsr_state = lfsr_step(lfsr_state);
    end
    return w;
  endfunction

  task automatic apply_row(input row_t row);
    logic [3:0] idx;
    idx = row.bpc[6:3];
    if ((row.kind & k_fence) != '0) begin
      // Fresh word at the fence target, read back after the fence.
      copy[row.faddr[10:3]] = random_word();
      load.valid = 1'b1;
      load.addr = row.faddr;
      load.data = copy[row.faddr[10:3]];
      @(posedge clock);
      #10;
      load = '0;
    end
    csr.trap = (row.kind & k_trap) != '0;
    csr.mret = (row.kind & k_mret) != '0;
    csr.mtvec = row.mtvec;
    csr.mepc = row.mepc;
    exec.jump = (row.kind & k_jump) != '0;
    exec.jump_addr = row.jaddr;
    exec.fence = (row.kind & k_fence) != '0;
    exec.fence_npc = row.faddr;
    resolve.valid = (row.kind & (k_taken | k_not_taken)) != '0;
    resolve.taken = (row.kind & k_taken) != '0;
    resolve.pc = row.bpc;
    resolve.npc = row.bpc + 32'd8;
    resolve.target = row.btgt;
    if ((row.kind & k_taken) != '0) begin
      btc_valid[idx] = 1'b1;
      btc_pc[idx] = row.bpc;
      btc_target[idx] = row.btgt;
    end else if ((row.kind & k_not_taken) != '0 && btc_pc[idx] == row.bpc) begin
      btc_valid[idx] = 1'b0;
    end
    redirect_pc = row.exp_pc;
    redirect_seq = redirect_seq + 1;
    @(posedge clock);
    #10;
    csr = '0;
    exec = '0;
    resolve = '0;
  endtask

  initial begin
    lfsr_state = 32'hc284c621;
    reset = 1'b0;
    csr = '0;
    exec = '0;
    exec.clear = 1'b1;  // Hold fetch idle while memory loads.
    resolve = '0;
    load = '0;
    for (int i = 0; i < 16; i++) begin
      btc_valid[i] = 1'b0;
      btc_pc[i] = '0;
      btc_target[i] = '0;
    end
    rows[0] = '{6, k_trap, 32'h200, '0, '0, '0, '0, '0, 32'h200};
    rows[1] = '{9, k_mret, '0, 32'h48, '0, '0, '0, '0, 32'h48};
    rows[2] = '{11, k_trap | k_mret, 32'h280, 32'h60, '0, '0, '0, '0, 32'h280};
    rows[3] = '{13, k_jump, '0, '0, 32'h400, '0, '0, '0, 32'h400};
    rows[4] = '{15, k_fence, '0, '0, '0, 32'h500, '0, '0, 32'h500};
    rows[5] = '{17, k_taken, '0, '0, '0, '0, 32'h100, 32'h318, 32'h318};
    rows[6] = '{19, k_jump, '0, '0, 32'hf0, '0, '0, '0, 32'hf0};
    rows[7] = '{25, k_not_taken, '0, '0, '0, '0, 32'h100, 32'h318, 32'h108};
    rows[8] = '{27, k_trap | k_jump, 32'h600, '0, 32'h700, '0, '0, '0, 32'h600};
    rows[9] = '{29, k_jump | k_fence, '0, '0, 32'h680, 32'h780, '0, '0, 32'h680};
    repeat (4) @(posedge clock);
    #10;
    reset = 1'b1;
    for (int n = 0; n < 256; n++) begin
      @(posedge clock);
      #10;
      copy[n] = random_word();
      load.valid = 1'b1;
      load.addr = 32'(n) << 3;
      load.data = copy[n];
    end
    @(posedge clock);
    #10;
    load = '0;
    repeat (2) @(posedge clock);
    #10;
    exec.clear = 1'b0;
    running = 1'b1;
    for (int i = 0; i < row_count; i++) begin
      do begin
        @(posedge clock);
        #10;
      end while (beat_count < rows[i].after);
      apply_row(rows[i]);
    end
    while (beat_count < total_beats) begin
      @(posedge clock);
    end
    repeat (2) @(posedge clock);
    $display("Beats %0d, pc errors %0d, data errors %0d, flag errors %0d",
             beat_count, pc_errors, data_errors, flag_errors);
    if (pc_errors + data_errors + flag_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Beat checker and reference model.
  always @(negedge clock) begin
    if (running) begin
      assert (fetch_q.ready == last_beat) else begin
        flag_errors++;
        $display("Error: %0t fetch_q.ready got %b expected %b", $time, fetch_q.ready,
                 last_beat);
      end
    end
    if (running && last_beat) begin
      assert (fetch_q.pc == last_pc) else begin
        flag_errors++;
        $display("Error: %0t fetch_q.pc got %h expected %h", $time, fetch_q.pc, last_pc);
      end
      assert (fetch_q.rdata == copy[last_pc[10:3]]) else begin
        data_errors++;
        $display("Error: %0t fetch_q.rdata got %h expected %h", $time, fetch_q.rdata,
                 copy[last_pc[10:3]]);
      end
      assert (fetch_q.taken == last_taken) else begin
        flag_errors++;
        $display("Error: %0t fetch_q.taken got %b expected %b", $time, fetch_q.taken,
                 last_taken);
      end
      if (last_taken) begin
        assert (fetch_q.tpc == last_tpc) else begin
          flag_errors++;
          $display("Error: %0t fetch_q.tpc got %h expected %h", $time, fetch_q.tpc,
                   last_tpc);
        end
      end
    end
    last_beat = 1'b0;
    if (running && fetch.ready) begin
      if (redirect_seq != redirect_seen) begin
        cur_pc = redirect_pc;
        cur_taken = 1'b0;
        cur_tpc = '0;
        redirect_seen = redirect_seq;
      end else begin
        cur_pc = next_pc;
        cur_taken = next_taken;
        cur_tpc = next_tpc;
      end
      assert (fetch.pc == cur_pc) else begin
        pc_errors++;
        $display("Error: %0t fetch.pc got %h expected %h", $time, fetch.pc, cur_pc);
      end
      assert (fetch.rdata == copy[cur_pc[10:3]]) else begin
        data_errors++;
        $display("Error: %0t fetch.rdata got %h expected %h", $time, fetch.rdata,
                 copy[cur_pc[10:3]]);
      end
      assert (fetch.taken == cur_taken) else begin
        flag_errors++;
        $display("Error: %0t fetch.taken got %b expected %b", $time, fetch.taken, cur_taken);
      end
      if (cur_taken) begin
        assert (fetch.tpc == cur_tpc) else begin
          flag_errors++;
          $display("Error: %0t fetch.tpc got %h expected %h", $time, fetch.tpc, cur_tpc);
        end
      end
      bidx = cur_pc[6:3];
      if (btc_valid[bidx] && btc_pc[bidx] == cur_pc) begin
        next_pc = btc_target[bidx];  // Learned branch.
        next_taken = 1'b1;
        next_tpc = cur_pc;
      end else begin
        next_pc = cur_pc + 32'd8;
        next_taken = 1'b0;
        next_tpc = '0;
      end
      last_pc = cur_pc;
      last_taken = cur_taken;
      last_tpc = cur_tpc;
      last_beat = 1'b1;
      beat_count++;
    end
  end

  always @(posedge clock) begin
    if (running) begin
      cycles++;
      if (cycles > cycle_limit) begin
        $display("Timeout after %0d cycles with %0d of %0d beats delivered",
                 cycles, beat_count, total_beats);
        $display("*** FAILED ***");
        $finish;
      end
    end
  end

endmodule

// ==== verilog.f ====
hdl/fetch_pkg.sv
hdl/fetch_stage.sv
hdl/branch_target_cache.sv
hdl/instr_memory.sv
hdl/fetch_unit.sv
testbench/fetch_unit_assertions.sv
testbench/fetch_unit_tb.sv

// ==== Makefile ====
# Verilator build and run for the fetch unit testbench.
VERILATOR ?= verilator
TOP ?= fetch_unit_tb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --assert -j 0
PASS_TEXT ?= *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
